// ==== hdl/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Address map of the core

`define CPU_RESET_PC 32'h0000_0100  // First fetch after reset
`define CPU_HALT_PC  32'h0000_0000  // JR here stops the core

// Datapath sizes

`define CPU_XLEN  32                // Data and address width
`define CPU_NREGS 32                // Architectural registers

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;   // Byte address of the word
        logic                 write;  // 1 = store, 0 = read
        logic [`CPU_XLEN-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;    // Operand b from sign-extended immediate
        logic       reg_write;
        logic [4:0] rd;         // Destination register
        logic       load;
        logic       store;
        logic       jr;
    } ctrl_t;

endpackage

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module alu import cpu_pkg::*; (
    input  alu_op_e              op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] y
);

    logic signed_lt;

    assign signed_lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;           // Also load/store address
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_SLT: y = {{(`CPU_XLEN-1){1'b0}}, signed_lt};
            default: y = '0;
        endcase
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [4:0]           rs_idx,
    input  logic [4:0]           rt_idx,
    output logic [`CPU_XLEN-1:0] rs_data,
    output logic [`CPU_XLEN-1:0] rt_data,
    input  logic                 we,
    input  logic [4:0]           wd_idx,
    input  logic [`CPU_XLEN-1:0] wd
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end else if (we && wd_idx != 5'd0) begin
            regs[wd_idx] <= wd;       // r0 stays zero
        end
    end

    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetch_unit import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    output bus_req_t             req,
    output logic                 req_valid,
    input  logic                 req_ready,
    input  bus_rsp_t             rsp,
    output logic [`CPU_XLEN-1:0] instr,
    output logic                 instr_valid,
    input  logic                 next_instr,
    input  logic                 redirect,
    input  logic [`CPU_XLEN-1:0] redirect_pc,
    input  logic                 halt
);

    logic [`CPU_XLEN-1:0] pc;        // Next word to request
    logic [`CPU_XLEN-1:0] req_addr;  // Address of the outstanding read
    logic [`CPU_XLEN-1:0] buf_q;
    logic                 full;
    logic                 pending;
    logic                 drop;      // Stale read still on the bus

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= `CPU_RESET_PC;
            full    <= 1'b0;
            pending <= 1'b0;
            drop    <= 1'b0;
        end else if (redirect) begin
            pc      <= redirect_pc;
            full    <= 1'b0;
            pending <= pending && !req_ready;  // A granted read must still finish
            drop    <= pending && !req_ready;
        end else begin
            if (next_instr)
                full <= 1'b0;                  // Word handed to the controller
            if (pending && req_ready) begin
                pending <= 1'b0;
                drop    <= 1'b0;
                if (!drop)
                    full <= 1'b1;
            end else if (!pending && (!full || next_instr) && !halt) begin
                pending  <= 1'b1;
                req_addr <= pc;
                pc       <= pc + 4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pending && req_ready && !drop && !redirect)
            buf_q <= rsp.rdata;
    end

    assign req         = '{addr: req_addr, write: 1'b0, wdata: '0};
    assign req_valid   = pending && !halt;
    assign instr       = buf_q;
    assign instr_valid = full;

endmodule

// ==== hdl/mem_unit.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module mem_unit import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 is_store,
    input  logic [`CPU_XLEN-1:0] addr,
    input  logic [`CPU_XLEN-1:0] store_data,
    output bus_req_t             req,
    output logic                 req_valid,
    input  logic                 req_ready,
    input  bus_rsp_t             rsp,
    output logic [`CPU_XLEN-1:0] load_data,
    output logic                 done
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            req_valid <= 1'b0;
        else if (start)
            req_valid <= 1'b1;
        else if (req_ready)
            req_valid <= 1'b0;   // Accepted by the arbiter
    end

    // Access held steady until the arbiter answers
    always_ff @(posedge clk) begin
        if (start)
            req <= '{addr: addr, write: is_store, wdata: store_data};
        if (req_valid && req_ready && !req.write)
            load_data <= rsp.rdata;
    end

    assign done = req_valid && req_ready;

endmodule

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module bus_arbiter import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bus_req_t             d_req,
    input  logic                 d_valid,
    output logic                 d_ready,
    input  bus_req_t             f_req,
    input  logic                 f_valid,
    output logic                 f_ready,
    output bus_rsp_t             rsp,
    output logic [`CPU_XLEN-1:0] address,
    output logic                 read,
    output logic                 write,
    output logic [`CPU_XLEN-1:0] writedata,
    input  logic                 waitrequest,
    input  logic [`CPU_XLEN-1:0] readdata
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_DATA, ARB_FETCH} arb_state_e;

    arb_state_e state;
    bus_req_t   sel;
    logic       busy;
    logic       xfer_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (d_valid)
                        state <= ARB_DATA;     // Data wins a tie
                    else if (f_valid)
                        state <= ARB_FETCH;
                end
                ARB_DATA, ARB_FETCH: begin
                    if (!waitrequest)
                        state <= ARB_IDLE;     // Decide again next cycle
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Requesters keep their request stable while granted
    always_comb begin
        sel       = (state == ARB_DATA) ? d_req : f_req;
        busy      = (state != ARB_IDLE);
        xfer_done = busy && !waitrequest;
        address   = sel.addr;
        writedata = sel.wdata;
        read      = busy && !sel.write;
        write     = busy && sel.write;
        d_ready   = xfer_done && (state == ARB_DATA);
        f_ready   = xfer_done && (state == ARB_FETCH);
        rsp.rdata = readdata;
    end

endmodule

// ==== hdl/core_ctrl.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module core_ctrl import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`CPU_XLEN-1:0] instr,
    input  logic                 instr_valid,
    output logic                 next_instr,
    output ctrl_t                ctrl,
    input  logic [`CPU_XLEN-1:0] rs_data,
    output logic                 mem_start,
    input  logic                 mem_done,
    output logic                 reg_we,
    output logic                 wb_sel,
    output logic                 redirect,
    output logic [`CPU_XLEN-1:0] redirect_pc,
    output logic                 halted
);

    typedef enum logic [2:0] {FETCH_WAIT, EXEC, MEM, WB, HALT} state_e;

    state_e  state;
    ctrl_t   dec;
    ctrl_t   ctrl_q;
    opcode_e op;
    funct_e  fn;
    logic    is_mem;
    logic    to_halt;

    assign op = opcode_e'(instr[31:26]);
    assign fn = funct_e'(instr[5:0]);

    // Decode of the incoming word; unknown encodings become a NOP
    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_ADD;
        case (op)
            OP_SPECIAL: begin
                dec.rd        = instr[15:11];
                dec.reg_write = 1'b1;
                case (fn)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_JR: begin
                        dec.jr        = 1'b1;
                        dec.reg_write = 1'b0;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.rd        = instr[20:16];   // rt is the target
                dec.load      = (op == OP_LW);
            end
            OP_SW: begin
                dec.use_imm = 1'b1;
                dec.store   = 1'b1;
            end
            default: ;
        endcase
    end

    assign is_mem  = ctrl_q.load || ctrl_q.store;
    assign to_halt = ctrl_q.jr && (rs_data == `CPU_HALT_PC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= FETCH_WAIT;
            ctrl_q <= '0;
        end else begin
            case (state)
                FETCH_WAIT: begin
                    if (instr_valid) begin
                        state  <= EXEC;
                        ctrl_q <= dec;
                    end
                end
                EXEC: begin
                    if (ctrl_q.jr)
                        state <= to_halt ? HALT : FETCH_WAIT;
                    else
                        state <= is_mem ? MEM : WB;
                end
                MEM:     if (mem_done) state <= WB;
                WB:      state <= FETCH_WAIT;
                HALT:    state <= HALT;         // Left only by reset
                default: state <= FETCH_WAIT;
            endcase
        end
    end

    assign next_instr  = (state == FETCH_WAIT) && instr_valid;
    assign ctrl        = ctrl_q;
    assign mem_start   = (state == EXEC) && is_mem;
    assign reg_we      = (state == WB) && ctrl_q.reg_write;
    assign wb_sel      = ctrl_q.load;           // Load data instead of ALU result
    assign redirect    = (state == EXEC) && ctrl_q.jr && !to_halt;
    assign redirect_pc = rs_data;
    assign halted      = (state == HALT);

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 active,
    output logic [`CPU_XLEN-1:0] address,
    output logic                 read,
    output logic                 write,
    output logic [`CPU_XLEN-1:0] writedata,
    input  logic                 waitrequest,
    input  logic [`CPU_XLEN-1:0] readdata
);

    bus_req_t             f_req, d_req;
    bus_rsp_t             rsp;
    logic                 f_valid, f_ready, d_valid, d_ready;
    logic [`CPU_XLEN-1:0] instr, redirect_pc, load_data;
    logic                 instr_valid, next_instr, redirect, halted;
    ctrl_t                ctrl;
    logic                 mem_start, mem_done, reg_we, wb_sel;
    logic [4:0]           rs_idx, rt_idx;
    logic [15:0]          imm;
    logic [`CPU_XLEN-1:0] rs_data, rt_data, alu_b, alu_y;

    // Operand fields of the instruction in execution
    always_ff @(posedge clk) begin
        if (next_instr) begin
            rs_idx <= instr[25:21];
            rt_idx <= instr[20:16];
            imm    <= instr[15:0];
        end
    end

    assign alu_b  = ctrl.use_imm ? {{(`CPU_XLEN-16){imm[15]}}, imm} : rt_data;
    assign active = !halted || read || write;   // Let the last fetch drain

    fetch_unit i_fetch_unit (
        .clk, .rst_n,
        .req (f_req), .req_valid (f_valid), .req_ready (f_ready), .rsp,
        .instr, .instr_valid, .next_instr,
        .redirect, .redirect_pc, .halt (halted)
    );

    mem_unit i_mem_unit (
        .clk, .rst_n,
        .start (mem_start), .is_store (ctrl.store),
        .addr (alu_y), .store_data (rt_data),
        .req (d_req), .req_valid (d_valid), .req_ready (d_ready), .rsp,
        .load_data, .done (mem_done)
    );

    bus_arbiter i_bus_arbiter (
        .clk, .rst_n,
        .d_req, .d_valid, .d_ready,
        .f_req, .f_valid, .f_ready,
        .rsp, .address, .read, .write, .writedata, .waitrequest, .readdata
    );

    core_ctrl i_core_ctrl (
        .clk, .rst_n,
        .instr, .instr_valid, .next_instr, .ctrl, .rs_data,
        .mem_start, .mem_done, .reg_we, .wb_sel,
        .redirect, .redirect_pc, .halted
    );

    reg_file i_reg_file (
        .clk, .rst_n,
        .rs_idx, .rt_idx, .rs_data, .rt_data,
        .we (reg_we), .wd_idx (ctrl.rd), .wd (wb_sel ? load_data : alu_y)
    );

    alu i_alu (
        .op (ctrl.alu_op), .a (rs_data), .b (alu_b), .y (alu_y)
    );

endmodule

// ==== bench/cpu_chk.sv ====
`timescale 1ns/100ps

module cpu_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        active,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic [31:0] address,
    input logic [31:0] writedata
);

    int fail_count = 0;  // Failed assertions so far

    // Avalon command held steady while the slave stalls
    a_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
        else begin
            fail_count++;
            $error("Avalon command changed while waitrequest was high");
        end

    a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n) !(read && write))
        else begin
            fail_count++;
            $error("read and write asserted together");
        end

    a_reset: assert property (@(posedge clk) $rose(rst_n) |-> !read && !write && active)
        else begin
            fail_count++;
            $error("bus or active not in reset state when reset released");
        end

endmodule

// ==== bench/cpu_checker.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_checker import cpu_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        active,
    input  logic        read,
    input  logic        write,
    input  logic        waitrequest,
    input  logic [31:0] address,
    input  logic [31:0] writedata,
    input  logic        start,
    input  logic        finish,
    input  int          prog_id,
    input  logic [31:0] image [MEM_WORDS],
    output int          n_pass,
    output int          n_fail,
    output int          n_errors
);

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          store_idx;
    int          prog_errs;
    logic        first_cmd;
    logic        halt_seen;  // active has dropped in this program

    // Instruction-level run of the whole program that collects the stores
    task automatic predict();
        logic [31:0] r [32];
        logic [31:0] m [MEM_WORDS];
        logic [31:0] pc, ins, a, b, ea;
        logic        stop;
        int          steps;
        m = image;
        for (int i = 0; i < 32; i++)
            r[i] = '0;
        exp_addr.delete();
        exp_data.delete();
        pc    = `CPU_RESET_PC;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < 4 * MEM_WORDS) begin
            ins = m[pc[13:2]];
            a   = r[ins[25:21]];
            b   = r[ins[20:16]];
            ea  = a + {{16{ins[15]}}, ins[15:0]};  // Sign-extended offset
            pc  = pc + 4;
            steps++;
            case (ins[31:26])
                OP_SPECIAL: begin
                    case (ins[5:0])
                        FN_ADDU: r[ins[15:11]] = a + b;
                        FN_SUBU: r[ins[15:11]] = a - b;
                        FN_AND:  r[ins[15:11]] = a & b;
                        FN_OR:   r[ins[15:11]] = a | b;
                        FN_XOR:  r[ins[15:11]] = a ^ b;
                        FN_SLT:  r[ins[15:11]] = {31'd0, $signed(a) < $signed(b)};
                        FN_JR:   if (a == `CPU_HALT_PC) stop = 1'b1; else pc = a;
                        default: ;
                    endcase
                end
                OP_ADDIU: r[ins[20:16]] = ea;
                OP_LW:    r[ins[20:16]] = m[ea[13:2]];
                OP_SW: begin
                    m[ea[13:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                default: ;
            endcase
            r[0] = '0;
        end
    endtask

    initial begin
        n_pass    = 0;
        n_fail    = 0;
        n_errors  = 0;
        prog_errs = 0;
        store_idx = 0;
        first_cmd = 1'b0;
        halt_seen = 1'b0;
    end

    always @(posedge clk) begin
        if (start) begin
            predict();
            store_idx = 0;
            prog_errs = 0;
            first_cmd = 1'b1;
            halt_seen = 1'b0;
        end else if (finish) begin
            if (store_idx != exp_addr.size()) begin
                $display("ERROR prog%0d store count: expected %0d actual %0d",
                         prog_id, exp_addr.size(), store_idx);
                prog_errs++;
            end
            if (active) begin
                $display("prog%0d: the CPU did not halt", prog_id);
                prog_errs++;
            end
            if (prog_errs == 0) begin
                n_pass++;
                $display("prog%0d: passed, %0d stores", prog_id, store_idx);
            end else begin
                n_fail++;
                $display("prog%0d: failed with %0d errors", prog_id, prog_errs);
            end
            n_errors += prog_errs;
        end else if (rst_n) begin
            if ((read || write) && first_cmd) begin
                first_cmd = 1'b0;
                if (!read || address != `CPU_RESET_PC) begin
                    $display("ERROR prog%0d first fetch: expected %h actual %h",
                             prog_id, `CPU_RESET_PC, address);
                    prog_errs++;
                end
            end
            if (halt_seen && (read || write)) begin
                $display("prog%0d: a bus command appeared after the halt", prog_id);
                prog_errs++;
            end
            if (!active)
                halt_seen = 1'b1;
            if (write && !waitrequest) begin
                if (store_idx >= exp_addr.size()) begin
                    $display("prog%0d: store to %h beyond the predicted ones", prog_id, address);
                    prog_errs++;
                end else if (address != exp_addr[store_idx]) begin
                    $display("ERROR prog%0d store %0d address: expected %h actual %h",
                             prog_id, store_idx, exp_addr[store_idx], address);
                    prog_errs++;
                end else if (writedata != exp_data[store_idx]) begin
                    $display("ERROR prog%0d store %0d data: expected %h actual %h",
                             prog_id, store_idx, exp_data[store_idx], writedata);
                    prog_errs++;
                end
                store_idx++;
            end
        end
    end

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int MEM_WORDS   = 4096;
    localparam int N_PROGS     = 8;
    localparam int PROG_LEN    = 24;
    localparam int WORST_CPI   = 24;    // Fetch and data stalls back to back
    localparam int WATCHDOG_NS = N_PROGS * (PROG_LEN * WORST_CPI + 20) * 8;

    logic        clk, rst_n, active, read, write;
    logic        waitrequest = 1'b1;
    logic [31:0] address, writedata;
    logic [31:0] readdata = '0;
    logic        start, finish;
    int          prog_id;
    logic [31:0] image [MEM_WORDS];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] gseed, mseed;
    int          stall;
    logic        loaded;
    int          n_pass, n_fail, n_errors;

    cpu_top i_cpu_top (.*);

    cpu_checker #(.MEM_WORDS(MEM_WORDS)) i_cpu_checker (.*);

    bind cpu_top cpu_chk i_cpu_chk (.*);

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rtype(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Random program at the reset address with an optional forward JR and a final halt
    task automatic gen_program();
        int          base, jr_at, skip, sel;
        logic [4:0]  rs, rt, rd;
        logic [15:0] daddr;
        base = `CPU_RESET_PC / 4;
        for (int i = 0; i < MEM_WORDS; i++)
            image[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
        gseed = lcg(gseed);
        jr_at = gseed[30] ? 2 + int'(gseed[27:24]) % 9 : -1;
        skip  = 1 + int'(gseed[21:20]) % 3;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            gseed = lcg(gseed);
            rs    = {2'b0, gseed[31:29]};
            rt    = {2'b0, gseed[28:26]};
            rd    = {2'b0, gseed[25:23]};
            sel   = int'(gseed[22:19]) % 10;
            daddr = 16'h1000 + {11'd0, gseed[2:0], 2'b00};  // Eight-word data region
            if (i == jr_at)
                image[base + i] = itype(OP_ADDIU, 5'd0, 5'd8,
                                        16'((jr_at + 2 + skip) * 4 + `CPU_RESET_PC));
            else if (i == jr_at + 1)
                image[base + i] = rtype(FN_JR, 5'd8, 5'd0, 5'd0);
            else
                case (sel)
                    0: image[base + i] = rtype(FN_ADDU, rs, rt, rd);
                    1: image[base + i] = rtype(FN_SUBU, rs, rt, rd);
                    2: image[base + i] = rtype(FN_AND, rs, rt, rd);
                    3: image[base + i] = rtype(FN_OR, rs, rt, rd);
                    4: image[base + i] = rtype(FN_XOR, rs, rt, rd);
                    5: image[base + i] = rtype(FN_SLT, rs, rt, rd);
                    6: image[base + i] = itype(OP_ADDIU, rs, rd, gseed[15:0]);
                    9: image[base + i] = itype(OP_LW, 5'd0, rd, daddr);
                    default: image[base + i] = itype(OP_SW, 5'd0, rt, daddr);
                endcase
        end
        image[base + PROG_LEN - 1] = rtype(FN_JR, 5'd0, 5'd0, 5'd0);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Avalon slave model with one forced wait cycle and 0 to 3 random extra ones
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waitrequest <= 1'b1;
            readdata    <= '0;
            loaded       = 1'b0;
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= image[i];
        end else if (read || write) begin
            if (!waitrequest) begin
                waitrequest <= 1'b1;
                loaded       = 1'b0;
                if (write)
                    mem[address[13:2]] <= writedata;
            end else begin
                if (!loaded) begin
                    mseed  = lcg(mseed);
                    stall  = int'(mseed[31:30]);
                    loaded = 1'b1;
                end
                if (stall == 0) begin
                    waitrequest <= 1'b0;
                    readdata    <= mem[address[13:2]];
                end else begin
                    stall--;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all programs finished");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        start   = 1'b0;
        finish  = 1'b0;
        prog_id = 0;
        gseed   = 32'he7f4;
        mseed   = 32'he7f4;
        for (int p = 0; p < N_PROGS; p++) begin
            gen_program();
            rst_n <= 1'b0;
            repeat (2) @(posedge clk);
            rst_n   <= 1'b1;
            start   <= 1'b1;
            prog_id <= p;
            @(posedge clk);
            start <= 1'b0;
            while (active)
                @(posedge clk);
            repeat (3) @(posedge clk);  // Quiet bus after the halt
            finish <= 1'b1;
            @(posedge clk);
            finish <= 1'b0;
        end
        repeat (2) @(posedge clk);
        $display("Summary: %0d programs passed, %0d failed, %0d errors, %0d assertion failures",
                 n_pass, n_fail, n_errors, i_cpu_top.i_cpu_chk.fail_count);
        if (n_fail == 0 && n_errors == 0 && i_cpu_top.i_cpu_chk.fail_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/mem_unit.sv
hdl/bus_arbiter.sv
hdl/core_ctrl.sv
hdl/cpu_top.sv
bench/cpu_chk.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module cpu_tb -Mdir obj_dir
output=$(./obj_dir/Vcpu_tb)
echo "$output"
if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
